// File: mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// Memory sizes in words
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);
	localparam int NUM_REGS   = 32;

	////////////////////
	// Opcodes
	////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type function codes
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_JR  = 6'h08;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// ALU_ADD is zero so a bubble decodes to a harmless add
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_t;

	// ALU operand source where EX/MEM wins over MEM/WB
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_WB,
		FWD_MEM
	} fwd_sel_t;

	////////////////////
	// Stage payloads
	////////////////////
	typedef struct packed {
		logic    reg_dest;
		logic    alu_src;
		alu_op_t alu_op;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    reg_write;
		logic    zero_ext;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pc_plus4;
	} if_id_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     rd1;
		word_t     rd2;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
	} id_ex_t;

	typedef struct packed {
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t dest;
		logic      mem_read;
		logic      mem_write;
		logic      mem_to_reg;
		logic      reg_write;
	} ex_mem_t;

	typedef struct packed {
		word_t     read_data;
		word_t     alu_result;
		reg_addr_t dest;
		logic      mem_to_reg;
		logic      reg_write;
	} mem_wb_t;

endpackage

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// All-zero payload has no control bits set, so it acts as a bubble
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
	import mips_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   stall,
	input  word_t  pc_target,
	input  logic   redirect,
	input  logic   imem_load,
	input  word_t  imem_addr,
	input  word_t  imem_data,
	output if_id_t fetched
);

	word_t pc;
	word_t pc_plus4;
	word_t imem [IMEM_WORDS];

	assign pc_plus4 = pc + 32'd4;

	// Redirect never comes together with a stall
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= pc_target;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

	// Program load port takes a byte address
	always_ff @(posedge clk) begin
		if (imem_load) begin
			imem[imem_addr[IMEM_AW+1:2]] <= imem_data;
		end
	end

	assign fetched.instr    = imem[pc[IMEM_AW+1:2]];
	assign fetched.pc_plus4 = pc_plus4;

endmodule

// File: decode_control.sv
`timescale 1ns/1ps

module decode_control
	import mips_pkg::*;
(
	input  word_t     instr,
	input  bit        ex_mem_read,
	input  bit        ex_reg_write,
	input  reg_addr_t ex_dest,
	input  bit        mem_mem_read,
	input  reg_addr_t mem_dest,
	output ctrl_t     ctrl,
	output logic      is_branch_eq,
	output logic      is_branch_ne,
	output logic      is_jump,
	output logic      is_jr,
	output logic      stall
);

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs;
	reg_addr_t  rt;
	ctrl_t      ctrl_dec;
	logic       jr_dec;
	logic       is_br;
	logic       uses_rt;
	logic       load_use;
	logic       ex_hit;
	logic       mem_hit;
	logic       branch_hazard;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];

	always_comb begin
		ctrl_dec = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl_dec.reg_dest  = 1'b1;
				ctrl_dec.reg_write = 1'b1;
				case (funct)
					FN_ADD:  ctrl_dec.alu_op = ALU_ADD;
					FN_SUB:  ctrl_dec.alu_op = ALU_SUB;
					FN_AND:  ctrl_dec.alu_op = ALU_AND;
					FN_OR:   ctrl_dec.alu_op = ALU_OR;
					FN_SLT:  ctrl_dec.alu_op = ALU_SLT;
					FN_SLL:  ctrl_dec.alu_op = ALU_SLL;
					// jr and unknown functions write nothing
					default: ctrl_dec.reg_write = 1'b0;
				endcase
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_LUI: begin
				ctrl_dec.alu_src   = 1'b1;
				ctrl_dec.reg_write = 1'b1;
				ctrl_dec.zero_ext  = (opcode != OP_ADDI);
				case (opcode)
					OP_ANDI: ctrl_dec.alu_op = ALU_AND;
					OP_ORI:  ctrl_dec.alu_op = ALU_OR;
					OP_LUI:  ctrl_dec.alu_op = ALU_LUI;
					default: ctrl_dec.alu_op = ALU_ADD;
				endcase
			end
			OP_LW: begin
				ctrl_dec.alu_src    = 1'b1;
				ctrl_dec.mem_read   = 1'b1;
				ctrl_dec.mem_to_reg = 1'b1;
				ctrl_dec.reg_write  = 1'b1;
			end
			OP_SW: begin
				ctrl_dec.alu_src   = 1'b1;
				ctrl_dec.mem_write = 1'b1;
			end
			default: ctrl_dec = '0;
		endcase
	end

	assign jr_dec  = (opcode == OP_RTYPE) && (funct == FN_JR);
	assign is_br   = (opcode == OP_BEQ) || (opcode == OP_BNE);
	assign uses_rt = (opcode == OP_RTYPE) || (opcode == OP_SW) || is_br;

	////////////////////
	// Hazards
	////////////////////

	// Load in EX feeding this instruction
	assign load_use = ex_mem_read && (ex_dest != '0) &&
		((ex_dest == rs) || (uses_rt && ex_dest == rt));

	// Branch operands must be readable from the file or the EX/MEM ALU result
	assign ex_hit = ex_reg_write && (ex_dest != '0) &&
		((ex_dest == rs) || (is_br && ex_dest == rt));
	assign mem_hit = mem_mem_read && (mem_dest != '0) &&
		((mem_dest == rs) || (is_br && mem_dest == rt));
	assign branch_hazard = (is_br || jr_dec) && (ex_hit || mem_hit);

	assign stall = load_use || branch_hazard;

	// Stall turns this slot into a bubble
	assign ctrl         = stall ? '0 : ctrl_dec;
	assign is_branch_eq = !stall && (opcode == OP_BEQ);
	assign is_branch_ne = !stall && (opcode == OP_BNE);
	assign is_jump      = !stall && (opcode == OP_J);
	assign is_jr        = !stall && jr_dec;

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t read_addr_1,
	input  reg_addr_t read_addr_2,
	output word_t     read_data_1,
	output word_t     read_data_2,
	input  logic      write_en,
	input  reg_addr_t write_addr,
	input  word_t     write_data
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	// r0 reads zero and a same-cycle write shows through
	assign read_data_1 = (read_addr_1 == '0) ? '0 :
		(write_en && write_addr == read_addr_1) ? write_data : regs[read_addr_1];
	assign read_data_2 = (read_addr_2 == '0) ? '0 :
		(write_en && write_addr == read_addr_2) ? write_data : regs[read_addr_2];

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu
	import mips_pkg::*;
(
	input  alu_op_t    op,
	input  word_t      a,
	input  word_t      b,
	input  logic [4:0] shamt,
	output word_t      result
);

	logic less;

	// slt compares as signed values
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_SLT: begin
				result = {31'd0, less};
			end
			// Shift source is rt, which arrives on b
			ALU_SLL: begin
				result = b << shamt;
			end
			ALU_LUI: begin
				result = b << 16;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit
	import mips_pkg::*;
(
	input  reg_addr_t rs,
	input  reg_addr_t rt,
	input  reg_addr_t mem_dest,
	input  logic      mem_reg_write,
	input  reg_addr_t wb_dest,
	input  logic      wb_reg_write,
	output fwd_sel_t  forward_a,
	output fwd_sel_t  forward_b
);

	logic mem_valid;
	logic wb_valid;

	// Never forward r0
	assign mem_valid = mem_reg_write && (mem_dest != '0);
	assign wb_valid  = wb_reg_write && (wb_dest != '0);

	// Newest result first
	assign forward_a = (mem_valid && mem_dest == rs) ? FWD_MEM :
		(wb_valid && wb_dest == rs) ? FWD_WB : FWD_REG;
	assign forward_b = (mem_valid && mem_dest == rt) ? FWD_MEM :
		(wb_valid && wb_dest == rt) ? FWD_WB : FWD_REG;

endmodule

// File: data_memory.sv
`timescale 1ns/1ps

module data_memory
	import mips_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  write_en,
	input  word_t addr,
	input  word_t write_data,
	output word_t read_data
);

	word_t mem [DMEM_WORDS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (write_en) begin
			mem[addr[DMEM_AW+1:2]] <= write_data;
		end
	end

	// Word access with the low address bits ignored
	assign read_data = mem[addr[DMEM_AW+1:2]];

endmodule

// File: mips_pipeline.sv
`timescale 1ns/1ps

module mips_pipeline
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      imem_load,
	input  word_t     imem_addr,
	input  word_t     imem_data,
	output logic      reg_write_strobe,
	output reg_addr_t reg_write_addr,
	output word_t     reg_write_data,
	output logic      store_strobe,
	output word_t     store_addr,
	output word_t     store_data
);

	if_id_t  fetched;
	if_id_t  if_id_q;
	id_ex_t  id_ex_d;
	id_ex_t  id_ex_q;
	ex_mem_t ex_mem_d;
	ex_mem_t ex_mem_q;
	mem_wb_t mem_wb_d;
	mem_wb_t mem_wb_q;

	ctrl_t     ctrl;
	logic      is_branch_eq;
	logic      is_branch_ne;
	logic      is_jump;
	logic      is_jr;
	logic      stall;
	logic      branch_taken;
	logic      flush;
	word_t     pc_target;
	word_t     rd1;
	word_t     rd2;
	word_t     rs_val;
	word_t     rt_val;
	word_t     imm_sign;
	word_t     imm_ext;
	reg_addr_t id_rs;
	reg_addr_t id_rt;
	logic      mem_fwd_ok;

	reg_addr_t ex_dest;
	fwd_sel_t  forward_a;
	fwd_sel_t  forward_b;
	word_t     op_a;
	word_t     op_b;
	word_t     alu_b;
	word_t     alu_result;
	word_t     dmem_rdata;
	word_t     wb_data;

	////////////////////
	// Fetch
	////////////////////
	fetch_stage i_fetch_stage (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.pc_target (pc_target),
		.redirect  (flush),
		.imem_load (imem_load),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.fetched   (fetched)
	);

	pipe_reg #(.payload_t(if_id_t)) if_id (
		.clk   (clk),
		.reset (reset),
		.stall (stall),
		.flush (flush),
		.d     (fetched),
		.q     (if_id_q)
	);

	////////////////////
	// Decode
	////////////////////
	assign id_rs = if_id_q.instr[25:21];
	assign id_rt = if_id_q.instr[20:16];

	decode_control i_decode_control (
		.instr        (if_id_q.instr),
		.ex_mem_read  (id_ex_q.ctrl.mem_read),
		.ex_reg_write (id_ex_q.ctrl.reg_write),
		.ex_dest      (ex_dest),
		.mem_mem_read (ex_mem_q.mem_read),
		.mem_dest     (ex_mem_q.dest),
		.ctrl         (ctrl),
		.is_branch_eq (is_branch_eq),
		.is_branch_ne (is_branch_ne),
		.is_jump      (is_jump),
		.is_jr        (is_jr),
		.stall        (stall)
	);

	register_file i_register_file (
		.clk         (clk),
		.reset       (reset),
		.read_addr_1 (id_rs),
		.read_addr_2 (id_rt),
		.read_data_1 (rd1),
		.read_data_2 (rd2),
		.write_en    (mem_wb_q.reg_write),
		.write_addr  (mem_wb_q.dest),
		.write_data  (wb_data)
	);

	assign imm_sign = {{16{if_id_q.instr[15]}}, if_id_q.instr[15:0]};
	assign imm_ext  = ctrl.zero_ext ? {16'd0, if_id_q.instr[15:0]} : imm_sign;

	// ALU result in MEM feeds the branch compare while a load there stalls
	assign mem_fwd_ok = ex_mem_q.reg_write && (ex_mem_q.dest != '0);
	assign rs_val = (mem_fwd_ok && ex_mem_q.dest == id_rs) ? ex_mem_q.alu_result : rd1;
	assign rt_val = (mem_fwd_ok && ex_mem_q.dest == id_rt) ? ex_mem_q.alu_result : rd2;

	assign branch_taken = (is_branch_eq && rs_val == rt_val) ||
		(is_branch_ne && rs_val != rt_val);
	assign flush = branch_taken || is_jump || is_jr;

	always_comb begin
		if (is_jr) begin
			pc_target = rs_val;
		end else if (is_jump) begin
			pc_target = {if_id_q.pc_plus4[31:28], if_id_q.instr[25:0], 2'b00};
		end else begin
			pc_target = if_id_q.pc_plus4 + {imm_sign[29:0], 2'b00};
		end
	end

	assign id_ex_d = '{
		ctrl:  ctrl,
		rd1:   rd1,
		rd2:   rd2,
		imm:   imm_ext,
		rs:    id_rs,
		rt:    id_rt,
		rd:    if_id_q.instr[15:11],
		shamt: if_id_q.instr[10:6]
	};

	// Bubble comes in through ctrl
	pipe_reg #(.payload_t(id_ex_t)) id_ex (
		.clk   (clk),
		.reset (reset),
		.stall (1'b0),
		.flush (1'b0),
		.d     (id_ex_d),
		.q     (id_ex_q)
	);

	////////////////////
	// Execute
	////////////////////
	assign ex_dest = id_ex_q.ctrl.reg_dest ? id_ex_q.rd : id_ex_q.rt;

	forwarding_unit i_forwarding_unit (
		.rs            (id_ex_q.rs),
		.rt            (id_ex_q.rt),
		.mem_dest      (ex_mem_q.dest),
		.mem_reg_write (ex_mem_q.reg_write),
		.wb_dest       (mem_wb_q.dest),
		.wb_reg_write  (mem_wb_q.reg_write),
		.forward_a     (forward_a),
		.forward_b     (forward_b)
	);

	always_comb begin
		case (forward_a)
			FWD_MEM: op_a = ex_mem_q.alu_result;
			FWD_WB:  op_a = wb_data;
			default: op_a = id_ex_q.rd1;
		endcase
	end

	always_comb begin
		case (forward_b)
			FWD_MEM: op_b = ex_mem_q.alu_result;
			FWD_WB:  op_b = wb_data;
			default: op_b = id_ex_q.rd2;
		endcase
	end

	assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : op_b;

	alu i_alu (
		.op     (id_ex_q.ctrl.alu_op),
		.a      (op_a),
		.b      (alu_b),
		.shamt  (id_ex_q.shamt),
		.result (alu_result)
	);

	assign ex_mem_d = '{
		alu_result: alu_result,
		store_data: op_b,
		dest:       ex_dest,
		mem_read:   id_ex_q.ctrl.mem_read,
		mem_write:  id_ex_q.ctrl.mem_write,
		mem_to_reg: id_ex_q.ctrl.mem_to_reg,
		reg_write:  id_ex_q.ctrl.reg_write
	};

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem (
		.clk   (clk),
		.reset (reset),
		.stall (1'b0),
		.flush (1'b0),
		.d     (ex_mem_d),
		.q     (ex_mem_q)
	);

	////////////////////
	// Memory and write-back
	////////////////////
	data_memory i_data_memory (
		.clk        (clk),
		.reset      (reset),
		.write_en   (ex_mem_q.mem_write),
		.addr       (ex_mem_q.alu_result),
		.write_data (ex_mem_q.store_data),
		.read_data  (dmem_rdata)
	);

	assign mem_wb_d = '{
		read_data:  dmem_rdata,
		alu_result: ex_mem_q.alu_result,
		dest:       ex_mem_q.dest,
		mem_to_reg: ex_mem_q.mem_to_reg,
		reg_write:  ex_mem_q.reg_write
	};

	pipe_reg #(.payload_t(mem_wb_t)) mem_wb (
		.clk   (clk),
		.reset (reset),
		.stall (1'b0),
		.flush (1'b0),
		.d     (mem_wb_d),
		.q     (mem_wb_q)
	);

	assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.read_data : mem_wb_q.alu_result;

	// Report strobes skip writes to r0
	assign reg_write_strobe = mem_wb_q.reg_write && (mem_wb_q.dest != '0);
	assign reg_write_addr   = mem_wb_q.dest;
	assign reg_write_data   = wb_data;

	assign store_strobe = ex_mem_q.mem_write;
	assign store_addr   = ex_mem_q.alu_result;
	assign store_data   = ex_mem_q.store_data;

endmodule

// File: tb_mips_pipeline.sv
`timescale 1ns/1ps

module tb_mips_pipeline
	import mips_pkg::*;
();

	localparam int PERIOD           = 4;
	localparam int CYCLES_PER_INSTR = 40;
	localparam int MODEL_STEPS      = 1000;

	typedef struct packed {
		reg_addr_t addr;
		word_t     data;
	} reg_write_t;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	logic      clk;
	logic      reset;
	logic      imem_load;
	word_t     imem_addr;
	word_t     imem_data;
	logic      reg_write_strobe;
	reg_addr_t reg_write_addr;
	word_t     reg_write_data;
	logic      store_strobe;
	word_t     store_addr;
	word_t     store_data;

	integer     seed = 32'hd3f;
	word_t      prog [$];
	reg_write_t exp_rw [$];
	store_t     exp_st [$];
	int         cycles_out_of_reset;
	bit         armed;
	time        deadline;

	mips_pipeline i_mips_pipeline (
		.clk              (clk),
		.reset            (reset),
		.imem_load        (imem_load),
		.imem_addr        (imem_addr),
		.imem_data        (imem_data),
		.reg_write_strobe (reg_write_strobe),
		.reg_write_addr   (reg_write_addr),
		.reg_write_data   (reg_write_data),
		.store_strobe     (store_strobe),
		.store_addr       (store_addr),
		.store_data       (store_data)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic error_stop(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic mismatch_stop(input string name, input word_t expected, input word_t actual);
		error_stop($sformatf("MISMATCH at %0t: %s expected %h, got %h",
			$time, name, expected, actual));
	endtask

	////////////////////
	// Assembler
	////////////////////
	function automatic word_t rtype_word(input logic [5:0] funct, input reg_addr_t rs,
		input reg_addr_t rt, input reg_addr_t rd, input logic [4:0] shamt);
		return {OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(input word_t target);
		return {OP_J, target[27:2]};
	endfunction

	function automatic logic [15:0] rand16();
		return 16'($random(seed));
	endfunction

	// Word address with room for a +4 offset
	function automatic logic [15:0] rand_addr();
		return 16'(({$random(seed)} % (DMEM_WORDS - 2)) * 4);
	endfunction

	task automatic build_program(input int which);
		logic [15:0] addr_a;
		logic [15:0] addr_b;
		prog.delete();
		addr_a = rand_addr();
		addr_b = rand_addr();
		if (which == 0) begin
			// Dependent ALU chain followed by memory traffic
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, rand16()));
			prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd2, rand16()));
			prog.push_back(rtype_word(FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0));
			prog.push_back(rtype_word(FN_SUB, 5'd3, 5'd1, 5'd4, 5'd0));
			prog.push_back(rtype_word(FN_AND, 5'd4, 5'd3, 5'd5, 5'd0));
			prog.push_back(rtype_word(FN_OR, 5'd5, 5'd2, 5'd6, 5'd0));
			prog.push_back(rtype_word(FN_SLT, 5'd4, 5'd3, 5'd7, 5'd0));
			prog.push_back(rtype_word(FN_SLL, 5'd0, 5'd6, 5'd8, 5'd3));
			prog.push_back(itype_word(OP_ANDI, 5'd8, 5'd9, rand16()));
			prog.push_back(itype_word(OP_ORI, 5'd9, 5'd10, rand16()));
			prog.push_back(itype_word(OP_LUI, 5'd0, 5'd11, rand16()));
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd12, addr_a));
			prog.push_back(itype_word(OP_SW, 5'd12, 5'd10, 16'd0));
			prog.push_back(itype_word(OP_LW, 5'd12, 5'd13, 16'd0));
			prog.push_back(rtype_word(FN_ADD, 5'd13, 5'd1, 5'd14, 5'd0));
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd15, addr_b));
			prog.push_back(itype_word(OP_SW, 5'd15, 5'd14, 16'd4));
			prog.push_back(itype_word(OP_LW, 5'd15, 5'd16, 16'd4));
			// Store data straight from a load
			prog.push_back(itype_word(OP_SW, 5'd12, 5'd16, 16'd4));
			prog.push_back(itype_word(OP_LW, 5'd12, 5'd17, 16'd0));
			prog.push_back(rtype_word(FN_SLT, 5'd17, 5'd16, 5'd18, 5'd0));
		end else begin
			// Branches and jumps with byte addresses on the right
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, 16'd5));       // 0
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd2, 16'd5));       // 4
			prog.push_back(itype_word(OP_BEQ, 5'd1, 5'd2, 16'd2));        // 8
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd3, 16'd111));     // 12
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd3, 16'd222));     // 16
			prog.push_back(rtype_word(FN_SUB, 5'd1, 5'd2, 5'd4, 5'd0));   // 20
			prog.push_back(itype_word(OP_BNE, 5'd4, 5'd0, 16'd1));        // 24
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd5, 16'd7));       // 28
			prog.push_back(itype_word(OP_BNE, 5'd5, 5'd1, 16'd1));        // 32
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd6, 16'd99));      // 36
			prog.push_back(itype_word(OP_LW, 5'd0, 5'd7, 16'd0));         // 40
			prog.push_back(itype_word(OP_BEQ, 5'd7, 5'd0, 16'd1));        // 44
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd6, 16'd98));      // 48
			prog.push_back(rtype_word(FN_ADD, 5'd12, 5'd1, 5'd12, 5'd0)); // 52
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd8, 16'd72));      // 56
			prog.push_back(rtype_word(FN_JR, 5'd8, 5'd0, 5'd0, 5'd0));    // 60
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd9, 16'd1));       // 64
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd9, 16'd2));       // 68
			prog.push_back(jump_word(32'd84));                             // 72
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd10, 16'd1));      // 76
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd10, 16'd2));      // 80
			prog.push_back(itype_word(OP_BEQ, 5'd1, 5'd4, 16'd1));        // 84
			prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd11, 16'd3));      // 88
		end
		// Spin on itself once done
		prog.push_back(jump_word(prog.size() * 4));
	endtask

	////////////////////
	// Reference model
	////////////////////
	task automatic model_program();
		word_t     regs [NUM_REGS];
		word_t     dmem [DMEM_WORDS];
		word_t     pc;
		word_t     next_pc;
		word_t     instr;
		word_t     a;
		word_t     b;
		word_t     simm;
		word_t     addr;
		word_t     val;
		reg_addr_t dest;
		bit        wr_en;
		bit        done;
		int        steps;
		exp_rw.delete();
		exp_st.delete();
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		foreach (dmem[i]) begin
			dmem[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		for (steps = 0; steps < MODEL_STEPS && !done; steps++) begin
			instr   = prog[pc >> 2];
			a       = regs[instr[25:21]];
			b       = regs[instr[20:16]];
			simm    = {{16{instr[15]}}, instr[15:0]};
			addr    = a + simm;
			next_pc = pc + 32'd4;
			wr_en   = 1'b1;
			dest    = instr[20:16];
			val     = '0;
			case (instr[31:26])
				OP_RTYPE: begin
					dest = instr[15:11];
					case (instr[5:0])
						FN_ADD: val = a + b;
						FN_SUB: val = a - b;
						FN_AND: val = a & b;
						FN_OR:  val = a | b;
						FN_SLT: val = {31'd0, $signed(a) < $signed(b)};
						FN_SLL: val = b << instr[10:6];
						FN_JR: begin
							wr_en   = 1'b0;
							next_pc = a;
						end
						default: error_stop("reference model met an unknown function code");
					endcase
				end
				OP_ADDI: val = addr;
				OP_ANDI: val = a & {16'd0, instr[15:0]};
				OP_ORI:  val = a | {16'd0, instr[15:0]};
				OP_LUI:  val = {instr[15:0], 16'd0};
				OP_LW:   val = dmem[addr[DMEM_AW+1:2]];
				OP_SW: begin
					wr_en = 1'b0;
					dmem[addr[DMEM_AW+1:2]] = b;
					exp_st.push_back(store_t'{addr: addr, data: b});
				end
				OP_BEQ, OP_BNE: begin
					wr_en = 1'b0;
					if ((a == b) == (instr[31:26] == OP_BEQ)) begin
						next_pc = next_pc + {simm[29:0], 2'b00};
					end
				end
				OP_J: begin
					wr_en   = 1'b0;
					next_pc = {next_pc[31:28], instr[25:0], 2'b00};
					done    = (next_pc == pc);
				end
				default: error_stop("reference model met an unknown opcode");
			endcase
			if (wr_en && dest != '0) begin
				regs[dest] = val;
				exp_rw.push_back(reg_write_t'{addr: dest, data: val});
			end
			pc = next_pc;
		end
		if (!done) begin
			error_stop("reference model never reached the closing jump");
		end
	endtask

	////////////////////
	// Checks on the strobes
	////////////////////
	task automatic check_reg_write();
		reg_write_t expected;
		assert (exp_rw.size() > 0)
			else error_stop($sformatf("unexpected register write to r%0d at %0t",
				reg_write_addr, $time));
		expected = exp_rw.pop_front();
		assert (reg_write_addr == expected.addr)
			else mismatch_stop("reg_write_addr", word_t'(expected.addr), word_t'(reg_write_addr));
		assert (reg_write_data == expected.data)
			else mismatch_stop("reg_write_data", expected.data, reg_write_data);
	endtask

	task automatic check_store();
		store_t expected;
		assert (exp_st.size() > 0)
			else error_stop($sformatf("unexpected store to %h at %0t", store_addr, $time));
		expected = exp_st.pop_front();
		assert (store_addr == expected.addr)
			else mismatch_stop("store_addr", expected.addr, store_addr);
		assert (store_data == expected.data)
			else mismatch_stop("store_data", expected.data, store_data);
	endtask

	// Sampled on the falling edge away from the register updates
	always @(negedge clk) begin
		if (reset) begin
			cycles_out_of_reset = 0;
			assert (!reg_write_strobe && !store_strobe)
				else error_stop("a strobe was high while reset was held");
		end else begin
			// Nothing can reach MEM in the first three cycles
			if (cycles_out_of_reset < 3) begin
				assert (!reg_write_strobe && !store_strobe)
					else error_stop("a strobe was high before any instruction could retire");
			end
			cycles_out_of_reset++;
			if (reg_write_strobe) begin
				check_reg_write();
			end
			if (store_strobe) begin
				check_store();
			end
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			if (armed && $time > deadline) begin
				error_stop("timeout: the expected register writes and stores did not arrive");
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////
	task automatic run_program(input int which);
		build_program(which);
		model_program();
		@(posedge clk);
		#1;
		reset = 1'b1;
		foreach (prog[i]) begin
			imem_load = 1'b1;
			imem_addr = i * 4;
			imem_data = prog[i];
			@(posedge clk);
			#1;
		end
		imem_load = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset    = 1'b0;
		deadline = $time + 64'(prog.size() * CYCLES_PER_INSTR * PERIOD);
		armed    = 1'b1;
		while (exp_rw.size() != 0 || exp_st.size() != 0) begin
			@(posedge clk);
		end
		// Let the closing jump spin so a stray strobe shows up
		repeat (10) @(posedge clk);
		armed = 1'b0;
	endtask

	initial begin
		reset               = 1'b1;
		imem_load           = 1'b0;
		imem_addr           = '0;
		imem_data           = '0;
		armed               = 1'b0;
		deadline            = 0;
		cycles_out_of_reset = 0;
		run_program(0);
		run_program(1);
		// Rerun with new random values
		run_program(0);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: mips_pipeline.f
mips_pkg.sv
pipe_reg.sv
fetch_stage.sv
decode_control.sv
register_file.sv
alu.sv
forwarding_unit.sv
data_memory.sv
mips_pipeline.sv
tb_mips_pipeline.sv

// File: Makefile
# Verilator simulation of the MIPS pipeline testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_mips_pipeline -f mips_pipeline.f

# The log decides pass or fail
run: compile
	./obj_dir/Vtb_mips_pipeline | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
